//--- Bender.yml
package:
  name: periph

sources:
  - verilog/periph_pkg.sv
  - verilog/axil_xbar.sv
  - verilog/axil_sram.sv
  - verilog/axil_uart_tx.sv
  - verilog/axil_clint.sv
  - verilog/periph_top.sv
  - target: test
    files:
      - test/tb_periph_top.sv

//--- periph.f
verilog/periph_pkg.sv
verilog/axil_xbar.sv
verilog/axil_sram.sv
verilog/axil_uart_tx.sv
verilog/axil_clint.sv
verilog/periph_top.sv
test/tb_periph_top.sv

//--- test/periph_testdata.txt
# test kind addr wdata strb exp_rdata exp_resp  (hex; resp 0 OKAY, 2 SLVERR, 3 DECERR)
# kind R read, W write, M mtime read that must grow, X drain UART byte, I wait irq level
1 W 80000000 11223344 f 00000000 0
1 W 80000004 a5a5a5a5 f 00000000 0
1 W 80000000 deadbeef 5 00000000 0
1 W 80000004 0000cafe c 00000000 0
1 R 80000000 00000000 0 11ad33ef 0
1 R 80000004 00000000 0 0000a5a5 0
1 W 80000408 76543210 f 00000000 0
1 R 80000008 00000000 0 76543210 0
1 R 80000400 00000000 0 11ad33ef 0
2 R 40000000 00000000 0 00000000 3
2 W 40000000 12345678 f 00000000 3
2 R 80000004 00000000 0 0000a5a5 0
3 W 10000000 00000041 1 00000000 0
3 R 10000004 00000000 0 00000001 0
3 W 10000000 00000042 1 00000000 2
3 X 00000000 00000000 0 00000041 0
3 R 10000004 00000000 0 00000000 0
4 I 00000000 00000000 0 00000000 0
4 W 02004000 00000000 f 00000000 0
4 W 02004004 00000000 f 00000000 0
4 I 00000000 00000000 0 00000001 0
4 W 02004004 ffffffff f 00000000 0
4 I 00000000 00000000 0 00000000 0
5 M 0200bff8 00000000 0 00000000 0
5 R 80000000 00000000 0 11ad33ef 0
5 M 0200bff8 00000000 0 00000000 0
5 R 02000010 00000000 0 00000000 2
5 W 02000010 00000001 f 00000000 2
6 W 800003fc 0badf00d f 00000000 0
6 R 800003fc 00000000 0 0badf00d 0
6 R 10000004 00000000 0 00000000 0
6 R 80000008 00000000 0 76543210 0

//--- test/tb_periph_top.sv
module tb_periph_top;
  import periph_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int SEED    = 32'h4b1e745a;

  logic       clk;
  logic       rst;
  axi_ar_t    ar;
  logic       arvalid;
  logic       arready;
  axi_r_t     r;
  logic       rvalid;
  logic       rready;
  axi_aw_t    aw;
  logic       awvalid;
  logic       awready;
  axi_w_t     w;
  logic       wvalid;
  logic       wready;
  axi_b_t     b;
  logic       bvalid;
  logic       bready;
  logic [7:0] tx_data;
  logic       tx_valid;
  logic       tx_ready;
  logic       timer_irq;
  logic       tx_hold;      // Keeps the serializer stalled until the drain step
  logic [7:0] tx_seen [$];  // Bytes taken by the serializer model
  int         errors;
  int         test_errs;
  int         n_pass;
  int         n_fail;
  bit         aborted;

  periph_top #(
    .SRAM_WORDS(256)
  ) dut0 (
    .clk(clk), .rst(rst),
    .cpu_ar_i(ar), .cpu_arvalid_i(arvalid), .cpu_arready_o(arready),
    .cpu_r_o(r), .cpu_rvalid_o(rvalid), .cpu_rready_i(rready),
    .cpu_aw_i(aw), .cpu_awvalid_i(awvalid), .cpu_awready_o(awready),
    .cpu_w_i(w), .cpu_wvalid_i(wvalid), .cpu_wready_o(wready),
    .cpu_b_o(b), .cpu_bvalid_o(bvalid), .cpu_bready_i(bready),
    .tx_data_o(tx_data), .tx_valid_o(tx_valid), .tx_ready_i(tx_ready),
    .timer_irq_o(timer_irq)
  );

  always #20 clk = ~clk;

  // Random back-pressure on responses and on the byte stream
  always @(posedge clk) begin
    rready   <= ($urandom_range(0, 1) == 1);
    bready   <= ($urandom_range(0, 1) == 1);
    tx_ready <= !tx_hold && ($urandom_range(0, 1) == 1);
    if (tx_valid && tx_ready) tx_seen.push_back(tx_data);
  end

  // ------------------------------
  // Reporting
  // ------------------------------
  task automatic report_mismatch(string sig, logic [31:0] exp, logic [31:0] act);
    $display("[FAIL] t=%0t %s expected %h got %h", $time, sig, exp, act);
    errors++;
    test_errs++;
  endtask

  task automatic report_problem(string what);
    $display("[ERROR] t=%0t %s", $time, what);
    errors++;
    test_errs++;
  endtask

  task automatic close_test(int num);
    if (test_errs == 0) begin
      n_pass++;
      $display("test %0d ok", num);
    end else begin
      n_fail++;
      $display("test %0d FAIL with %0d errors", num, test_errs);
    end
    test_errs = 0;
  endtask

  // ------------------------------
  // Bus transactions
  // ------------------------------
  task automatic read_txn(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int     n;
    bit     seen;
    axi_r_t held;
    n    = 0;
    seen = 0;
    held = '0;
    data = '0;
    resp = 2'b00;
    @(posedge clk);
    ar      <= '{addr: addr};
    arvalid <= 1'b1;
    do begin
      @(posedge clk);
      n++;
    end while (!arready && n < TIMEOUT);
    arvalid <= 1'b0;
    if (!arready) begin
      report_problem("read address was not accepted within the timeout");
      aborted = 1;
      return;
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (arready) report_problem("arready rose before the read response was taken");
      if (seen && !rvalid) report_problem("rvalid dropped before rready");
      else if (seen && r !== held) report_mismatch("cpu_r_o.data (held)", held.data, r.data);
      if (rvalid) begin
        seen = 1;
        held = r;
      end
    end while (!(rvalid && rready) && n < TIMEOUT);
    if (!(rvalid && rready)) begin
      report_problem("no read response within the timeout");
      aborted = 1;
      return;
    end
    data = r.data;
    resp = r.resp;
  endtask

  task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int     n;
    bit     seen;
    axi_b_t held;
    n    = 0;
    seen = 0;
    held = '0;
    resp = 2'b00;
    @(posedge clk);
    aw      <= '{addr: addr};
    w       <= '{data: data, strb: strb};
    awvalid <= 1'b1;  // AW and W go out together
    wvalid  <= 1'b1;
    do begin
      @(posedge clk);
      n++;
    end while (!(awready && wready) && n < TIMEOUT);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (!(awready && wready)) begin
      report_problem("write address and data were not accepted within the timeout");
      aborted = 1;
      return;
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (seen && !bvalid) report_problem("bvalid dropped before bready");
      else if (seen && b !== held) report_mismatch("cpu_b_o.resp (held)", held.resp, b.resp);
      if (bvalid) begin
        seen = 1;
        held = b;
      end
    end while (!(bvalid && bready) && n < TIMEOUT);
    if (!(bvalid && bready)) begin
      report_problem("no write response within the timeout");
      aborted = 1;
      return;
    end
    resp = b.resp;
  endtask

  // Let the serializer run and expect one byte
  task automatic drain_uart(logic [7:0] exp);
    int n;
    n = 0;
    @(posedge clk);
    tx_hold <= 1'b0;
    do begin
      @(posedge clk);
      n++;
    end while (!(tx_valid && tx_ready) && n < TIMEOUT);
    if (!(tx_valid && tx_ready)) begin
      report_problem("the UART never handed a byte to the serializer");
      return;
    end
    if (tx_data !== exp) report_mismatch("tx_data_o", exp, tx_data);
    @(posedge clk);
    if (tx_seen.size() != 1) report_mismatch("tx byte count", 1, tx_seen.size());
  endtask

  task automatic wait_irq(logic level);
    int n;
    n = 0;
    while (timer_irq !== level && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (timer_irq !== level) report_mismatch("timer_irq_o", level, timer_irq);
  endtask

  // ------------------------------
  // Replay of the data file
  // ------------------------------
  initial begin
    int          fd;
    int          cnt;
    int          tnum;
    int          cur;
    string       line;
    logic [7:0]  kind;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic [31:0] data;
    logic [31:0] last_mtime;
    logic [3:0]  strb;
    logic [1:0]  exp_resp;
    logic [1:0]  resp;
    clk        = 1'b0;
    rst        = 1'b0;
    ar         = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    aw         = '0;
    awvalid    = 1'b0;
    w          = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    tx_ready   = 1'b0;
    tx_hold    = 1'b1;
    errors     = 0;
    test_errs  = 0;
    n_pass     = 0;
    n_fail     = 0;
    aborted    = 0;
    cur        = -1;
    last_mtime = '0;
    void'($urandom(SEED));
    fd = $fopen("test/periph_testdata.txt", "r");
    if (fd == 0) begin
      report_problem("cannot open test/periph_testdata.txt");
      aborted = 1;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    if (timer_irq !== 1'b0) report_mismatch("timer_irq_o", 0, timer_irq);
    while (!aborted && $fgets(line, fd)) begin
      if (line.len() == 0 || line.getc(0) == "#") continue;
      cnt = $sscanf(line, "%d %c %h %h %h %h %h", tnum, kind, addr, wdata, strb,
                    exp_data, exp_resp);
      if (cnt != 7) continue;
      if (tnum != cur) begin
        if (cur >= 0) close_test(cur);
        cur = tnum;
      end
      repeat ($urandom_range(0, 3)) @(posedge clk);  // Random gap between transactions
      case (kind)
        "R": begin
          read_txn(addr, data, resp);
          if (!aborted && resp !== exp_resp) report_mismatch("cpu_r_o.resp", exp_resp, resp);
          if (!aborted && data !== exp_data) report_mismatch("cpu_r_o.data", exp_data, data);
        end
        "W": begin
          write_txn(addr, wdata, strb, resp);
          if (!aborted && resp !== exp_resp) report_mismatch("cpu_b_o.resp", exp_resp, resp);
        end
        "M": begin
          read_txn(addr, data, resp);
          if (!aborted && resp !== exp_resp) report_mismatch("cpu_r_o.resp", exp_resp, resp);
          if (!aborted && !(data > last_mtime)) begin
            $display("[FAIL] t=%0t cpu_r_o.data expected above %h got %h", $time,
                     last_mtime, data);
            errors++;
            test_errs++;
          end
          last_mtime = data;
        end
        "X": drain_uart(exp_data[7:0]);
        "I": wait_irq(exp_data[0]);
        default: report_problem("unknown transaction kind in the data file");
      endcase
    end
    if (cur >= 0) close_test(cur);
    if (fd != 0) $fclose(fd);
    $display("passed %0d failed %0d", n_pass, n_fail);
    if (errors == 0 && !aborted && n_pass > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verilog/axil_clint.sv
module axil_clint (
  input  logic                 clk,
  input  logic                 rst,
  input  periph_pkg::axi_ar_t  ar_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  output periph_pkg::axi_r_t   r_o,
  output logic                 rvalid_o,
  input  logic                 rready_i,
  input  periph_pkg::axi_aw_t  aw_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  periph_pkg::axi_w_t   w_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  output periph_pkg::axi_b_t   b_o,
  output logic                 bvalid_o,
  input  logic                 bready_i,
  output logic                 timer_irq_o
);
  import periph_pkg::*;

  logic [ADDR_W-1:0] rd_ofs;
  logic [ADDR_W-1:0] wr_ofs;
  logic [63:0]       mtime_q;
  logic [63:0]       mtimecmp_q;
  logic              irq_q;
  logic              rd_fire;
  logic              wr_fire;
  logic              wr_hit;
  axi_r_t            r_q;
  axi_b_t            b_q;

  assign rd_ofs = ar_i.addr & (CLINT_SIZE - 1);
  assign wr_ofs = aw_i.addr & (CLINT_SIZE - 1);
  assign wr_hit = wr_ofs inside {CLINT_MTIMECMP_OFS, CLINT_MTIMECMP_OFS + 4,
                                 CLINT_MTIME_OFS, CLINT_MTIME_OFS + 4};

  assign arready_o = !rvalid_o;
  assign rd_fire   = arvalid_i && !rvalid_o;
  assign wr_fire   = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;

  assign r_o         = r_q;
  assign b_o         = b_q;
  assign timer_irq_o = irq_q;

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      r_q.resp <= RESP_OKAY;
      case (rd_ofs)
        CLINT_MTIMECMP_OFS:     r_q.data <= mtimecmp_q[31:0];
        CLINT_MTIMECMP_OFS + 4: r_q.data <= mtimecmp_q[63:32];
        CLINT_MTIME_OFS:        r_q.data <= mtime_q[31:0];
        CLINT_MTIME_OFS + 4:    r_q.data <= mtime_q[63:32];
        default: begin
          r_q.data <= '0;
          r_q.resp <= RESP_SLVERR;
        end
      endcase
    end
    if (wr_fire) b_q.resp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
  end

  // ------------------------------
  // Timer registers
  // ------------------------------
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;   // No interrupt until software programs a compare value
      irq_q      <= 1'b0;
      rvalid_o   <= 1'b0;
      bvalid_o   <= 1'b0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
      irq_q   <= (mtime_q >= mtimecmp_q);
      if (wr_fire) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (w_i.strb[b] && wr_ofs == CLINT_MTIMECMP_OFS)
            mtimecmp_q[8*b +: 8] <= w_i.data[8*b +: 8];
          if (w_i.strb[b] && wr_ofs == CLINT_MTIMECMP_OFS + 4)
            mtimecmp_q[32+8*b +: 8] <= w_i.data[8*b +: 8];
        end
        if (wr_ofs == CLINT_MTIME_OFS) mtime_q[31:0] <= w_i.data;  // Replaces the count
        if (wr_ofs == CLINT_MTIME_OFS + 4) mtime_q[63:32] <= w_i.data;
      end
      if (rd_fire) rvalid_o <= 1'b1;
      else if (rready_i) rvalid_o <= 1'b0;
      if (wr_fire) bvalid_o <= 1'b1;
      else if (bready_i) bvalid_o <= 1'b0;
    end
  end

endmodule

//--- verilog/axil_sram.sv
module axil_sram #(
  parameter int SRAM_WORDS = 1024
) (
  input  logic                 clk,
  input  logic                 rst,
  input  periph_pkg::axi_ar_t  ar_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  output periph_pkg::axi_r_t   r_o,
  output logic                 rvalid_o,
  input  logic                 rready_i,
  input  periph_pkg::axi_aw_t  aw_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  periph_pkg::axi_w_t   w_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  output periph_pkg::axi_b_t   b_o,
  output logic                 bvalid_o,
  input  logic                 bready_i
);
  import periph_pkg::*;

  localparam int IDX_W = $clog2(SRAM_WORDS);

  logic [DATA_W-1:0] mem [SRAM_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]  rd_idx;
  logic [IDX_W-1:0]  wr_idx;
  logic              rd_fire;
  logic              wr_fire;

  // Word index wraps modulo the array depth
  assign rd_idx = IDX_W'(ar_i.addr[ADDR_W-1:2] % SRAM_WORDS);
  assign wr_idx = IDX_W'(aw_i.addr[ADDR_W-1:2] % SRAM_WORDS);

  assign arready_o = !rvalid_o;
  assign rd_fire   = arvalid_i && !rvalid_o;
  assign wr_fire   = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;

  assign r_o = '{data: rdata_q, resp: RESP_OKAY};
  assign b_o = '{resp: RESP_OKAY};

  always_ff @(posedge clk) begin
    if (rd_fire) rdata_q <= mem[rd_idx];
    if (wr_fire) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (w_i.strb[b]) mem[wr_idx][8*b +: 8] <= w_i.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
    end else begin
      if (rd_fire) rvalid_o <= 1'b1;
      else if (rready_i) rvalid_o <= 1'b0;
      if (wr_fire) bvalid_o <= 1'b1;
      else if (bready_i) bvalid_o <= 1'b0;
    end
  end

endmodule

//--- verilog/axil_uart_tx.sv
module axil_uart_tx (
  input  logic                 clk,
  input  logic                 rst,
  input  periph_pkg::axi_ar_t  ar_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  output periph_pkg::axi_r_t   r_o,
  output logic                 rvalid_o,
  input  logic                 rready_i,
  input  periph_pkg::axi_aw_t  aw_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  periph_pkg::axi_w_t   w_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  output periph_pkg::axi_b_t   b_o,
  output logic                 bvalid_o,
  input  logic                 bready_i,
  output logic [7:0]           tx_data_o,
  output logic                 tx_valid_o,
  input  logic                 tx_ready_i
);
  import periph_pkg::*;

  logic [ADDR_W-1:0] rd_ofs;
  logic [ADDR_W-1:0] wr_ofs;
  logic [7:0]        tx_byte_q;   // Holding register
  logic              tx_full_q;
  logic              rd_fire;
  logic              wr_fire;
  logic              load;
  axi_r_t            r_q;
  axi_b_t            b_q;

  assign rd_ofs = ar_i.addr & (UART_SIZE - 1);
  assign wr_ofs = aw_i.addr & (UART_SIZE - 1);

  assign arready_o = !rvalid_o;
  assign rd_fire   = arvalid_i && !rvalid_o;
  assign wr_fire   = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;
  assign load = wr_fire && (wr_ofs == UART_TXDATA_OFS) && !tx_full_q && w_i.strb[0];

  assign r_o        = r_q;
  assign b_o        = b_q;
  assign tx_data_o  = tx_byte_q;
  assign tx_valid_o = tx_full_q;

  always_ff @(posedge clk) begin
    if (load) tx_byte_q <= w_i.data[7:0];
    if (rd_fire) begin
      r_q.data <= '0;
      r_q.resp <= RESP_OKAY;
      if (rd_ofs == UART_STATUS_OFS) r_q.data <= DATA_W'(tx_full_q);
      else if (rd_ofs != UART_TXDATA_OFS) r_q.resp <= RESP_SLVERR;
    end
    // A full holding register drops the byte and flags the write
    if (wr_fire) begin
      b_q.resp <= (wr_ofs != UART_TXDATA_OFS || tx_full_q) ? RESP_SLVERR : RESP_OKAY;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      tx_full_q <= 1'b0;
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;
    end else begin
      if (load) tx_full_q <= 1'b1;
      else if (tx_ready_i) tx_full_q <= 1'b0;  // Serializer took the byte
      if (rd_fire) rvalid_o <= 1'b1;
      else if (rready_i) rvalid_o <= 1'b0;
      if (wr_fire) bvalid_o <= 1'b1;
      else if (bready_i) bvalid_o <= 1'b0;
    end
  end

endmodule

//--- verilog/axil_xbar.sv
module axil_xbar (
  input  logic                 clk,
  input  logic                 rst,
  // CPU side
  input  periph_pkg::axi_ar_t  cpu_ar_i,
  input  logic                 cpu_arvalid_i,
  output logic                 cpu_arready_o,
  output periph_pkg::axi_r_t   cpu_r_o,
  output logic                 cpu_rvalid_o,
  input  logic                 cpu_rready_i,
  input  periph_pkg::axi_aw_t  cpu_aw_i,
  input  logic                 cpu_awvalid_i,
  output logic                 cpu_awready_o,
  input  periph_pkg::axi_w_t   cpu_w_i,
  input  logic                 cpu_wvalid_i,
  output logic                 cpu_wready_o,
  output periph_pkg::axi_b_t   cpu_b_o,
  output logic                 cpu_bvalid_o,
  input  logic                 cpu_bready_i,
  // SRAM
  output periph_pkg::axi_ar_t  sram_ar_o,
  output logic                 sram_arvalid_o,
  input  logic                 sram_arready_i,
  input  periph_pkg::axi_r_t   sram_r_i,
  input  logic                 sram_rvalid_i,
  output logic                 sram_rready_o,
  output periph_pkg::axi_aw_t  sram_aw_o,
  output logic                 sram_awvalid_o,
  input  logic                 sram_awready_i,
  output periph_pkg::axi_w_t   sram_w_o,
  output logic                 sram_wvalid_o,
  input  logic                 sram_wready_i,
  input  periph_pkg::axi_b_t   sram_b_i,
  input  logic                 sram_bvalid_i,
  output logic                 sram_bready_o,
  // UART
  output periph_pkg::axi_ar_t  uart_ar_o,
  output logic                 uart_arvalid_o,
  input  logic                 uart_arready_i,
  input  periph_pkg::axi_r_t   uart_r_i,
  input  logic                 uart_rvalid_i,
  output logic                 uart_rready_o,
  output periph_pkg::axi_aw_t  uart_aw_o,
  output logic                 uart_awvalid_o,
  input  logic                 uart_awready_i,
  output periph_pkg::axi_w_t   uart_w_o,
  output logic                 uart_wvalid_o,
  input  logic                 uart_wready_i,
  input  periph_pkg::axi_b_t   uart_b_i,
  input  logic                 uart_bvalid_i,
  output logic                 uart_bready_o,
  // CLINT
  output periph_pkg::axi_ar_t  clint_ar_o,
  output logic                 clint_arvalid_o,
  input  logic                 clint_arready_i,
  input  periph_pkg::axi_r_t   clint_r_i,
  input  logic                 clint_rvalid_i,
  output logic                 clint_rready_o,
  output periph_pkg::axi_aw_t  clint_aw_o,
  output logic                 clint_awvalid_o,
  input  logic                 clint_awready_i,
  output periph_pkg::axi_w_t   clint_w_o,
  output logic                 clint_wvalid_o,
  input  logic                 clint_wready_i,
  input  periph_pkg::axi_b_t   clint_b_i,
  input  logic                 clint_bvalid_i,
  output logic                 clint_bready_o
);
  import periph_pkg::*;

  localparam axi_r_t ERR_R = '{data: '0, resp: RESP_DECERR};
  localparam axi_b_t ERR_B = '{resp: RESP_DECERR};

  xbar_state_e state_q;
  xbar_state_e state_d;
  logic        err_taken;   // Address already accepted in an error state
  logic        rd_err_acc;
  logic        wr_err_acc;

  function automatic logic in_win(logic [ADDR_W-1:0] addr, logic [ADDR_W-1:0] base,
                                  logic [ADDR_W-1:0] size);
    return (addr >= base) && (addr < base + size);
  endfunction

  // Unmapped addresses fall through to the DECERR responder
  function automatic xbar_state_e decode(logic [ADDR_W-1:0] addr, logic rd);
    if (in_win(addr, SRAM_BASE, SRAM_SIZE)) return rd ? ST_RD_SRAM : ST_WR_SRAM;
    if (in_win(addr, UART_BASE, UART_SIZE)) return rd ? ST_RD_UART : ST_WR_UART;
    if (in_win(addr, CLINT_BASE, CLINT_SIZE)) return rd ? ST_RD_CLINT : ST_WR_CLINT;
    return rd ? ST_RD_ERR : ST_WR_ERR;
  endfunction

  // ------------------------------
  // Slave side steering
  // ------------------------------
  assign sram_ar_o       = (state_q == ST_RD_SRAM)  ? cpu_ar_i      : '0;
  assign sram_arvalid_o  = (state_q == ST_RD_SRAM)  ? cpu_arvalid_i : 1'b0;
  assign sram_rready_o   = (state_q == ST_RD_SRAM)  ? cpu_rready_i  : 1'b0;
  assign sram_aw_o       = (state_q == ST_WR_SRAM)  ? cpu_aw_i      : '0;
  assign sram_awvalid_o  = (state_q == ST_WR_SRAM)  ? cpu_awvalid_i : 1'b0;
  assign sram_w_o        = (state_q == ST_WR_SRAM)  ? cpu_w_i       : '0;
  assign sram_wvalid_o   = (state_q == ST_WR_SRAM)  ? cpu_wvalid_i  : 1'b0;
  assign sram_bready_o   = (state_q == ST_WR_SRAM)  ? cpu_bready_i  : 1'b0;

  assign uart_ar_o       = (state_q == ST_RD_UART)  ? cpu_ar_i      : '0;
  assign uart_arvalid_o  = (state_q == ST_RD_UART)  ? cpu_arvalid_i : 1'b0;
  assign uart_rready_o   = (state_q == ST_RD_UART)  ? cpu_rready_i  : 1'b0;
  assign uart_aw_o       = (state_q == ST_WR_UART)  ? cpu_aw_i      : '0;
  assign uart_awvalid_o  = (state_q == ST_WR_UART)  ? cpu_awvalid_i : 1'b0;
  assign uart_w_o        = (state_q == ST_WR_UART)  ? cpu_w_i       : '0;
  assign uart_wvalid_o   = (state_q == ST_WR_UART)  ? cpu_wvalid_i  : 1'b0;
  assign uart_bready_o   = (state_q == ST_WR_UART)  ? cpu_bready_i  : 1'b0;

  assign clint_ar_o      = (state_q == ST_RD_CLINT) ? cpu_ar_i      : '0;
  assign clint_arvalid_o = (state_q == ST_RD_CLINT) ? cpu_arvalid_i : 1'b0;
  assign clint_rready_o  = (state_q == ST_RD_CLINT) ? cpu_rready_i  : 1'b0;
  assign clint_aw_o      = (state_q == ST_WR_CLINT) ? cpu_aw_i      : '0;
  assign clint_awvalid_o = (state_q == ST_WR_CLINT) ? cpu_awvalid_i : 1'b0;
  assign clint_w_o       = (state_q == ST_WR_CLINT) ? cpu_w_i       : '0;
  assign clint_wvalid_o  = (state_q == ST_WR_CLINT) ? cpu_wvalid_i  : 1'b0;
  assign clint_bready_o  = (state_q == ST_WR_CLINT) ? cpu_bready_i  : 1'b0;

  // ------------------------------
  // CPU side steering
  // ------------------------------
  assign rd_err_acc = (state_q == ST_RD_ERR) && !err_taken && cpu_arvalid_i;
  assign wr_err_acc = (state_q == ST_WR_ERR) && !err_taken && cpu_awvalid_i && cpu_wvalid_i;

  assign cpu_arready_o = (state_q == ST_RD_SRAM)  ? sram_arready_i  :
                         (state_q == ST_RD_UART)  ? uart_arready_i  :
                         (state_q == ST_RD_CLINT) ? clint_arready_i :
                         (state_q == ST_RD_ERR)   ? !err_taken      : 1'b0;
  assign cpu_r_o       = (state_q == ST_RD_SRAM)  ? sram_r_i  :
                         (state_q == ST_RD_UART)  ? uart_r_i  :
                         (state_q == ST_RD_CLINT) ? clint_r_i :
                         (state_q == ST_RD_ERR)   ? ERR_R     : '0;
  assign cpu_rvalid_o  = (state_q == ST_RD_SRAM)  ? sram_rvalid_i  :
                         (state_q == ST_RD_UART)  ? uart_rvalid_i  :
                         (state_q == ST_RD_CLINT) ? clint_rvalid_i :
                         (state_q == ST_RD_ERR)   ? err_taken      : 1'b0;
  // AW and W are taken in the same cycle on every path
  assign cpu_awready_o = (state_q == ST_WR_SRAM)  ? sram_awready_i  :
                         (state_q == ST_WR_UART)  ? uart_awready_i  :
                         (state_q == ST_WR_CLINT) ? clint_awready_i : wr_err_acc;
  assign cpu_wready_o  = (state_q == ST_WR_SRAM)  ? sram_wready_i  :
                         (state_q == ST_WR_UART)  ? uart_wready_i  :
                         (state_q == ST_WR_CLINT) ? clint_wready_i : wr_err_acc;
  assign cpu_b_o       = (state_q == ST_WR_SRAM)  ? sram_b_i  :
                         (state_q == ST_WR_UART)  ? uart_b_i  :
                         (state_q == ST_WR_CLINT) ? clint_b_i :
                         (state_q == ST_WR_ERR)   ? ERR_B     : '0;
  assign cpu_bvalid_o  = (state_q == ST_WR_SRAM)  ? sram_bvalid_i  :
                         (state_q == ST_WR_UART)  ? uart_bvalid_i  :
                         (state_q == ST_WR_CLINT) ? clint_bvalid_i :
                         (state_q == ST_WR_ERR)   ? err_taken      : 1'b0;

  // ------------------------------
  // FSM
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (cpu_arvalid_i) state_d = decode(cpu_ar_i.addr, 1'b1);  // Reads win
        else if (cpu_awvalid_i) state_d = decode(cpu_aw_i.addr, 1'b0);
      end
      ST_RD_SRAM, ST_RD_UART, ST_RD_CLINT, ST_RD_ERR: begin
        if (cpu_rvalid_o && cpu_rready_i) state_d = ST_IDLE;
      end
      default: begin
        if (cpu_bvalid_o && cpu_bready_i) state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q   <= ST_IDLE;
      err_taken <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_d == ST_IDLE) err_taken <= 1'b0;
      else if (rd_err_acc || wr_err_acc) err_taken <= 1'b1;  // DECERR goes out next cycle
    end
  end

endmodule

//--- verilog/periph_pkg.sv
package periph_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam logic [ADDR_W-1:0] SRAM_BASE  = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] SRAM_SIZE  = 32'h0001_0000;  // 64 KiB
  localparam logic [ADDR_W-1:0] UART_BASE  = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] UART_SIZE  = 32'h0000_1000;  // 4 KiB
  localparam logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [ADDR_W-1:0] CLINT_SIZE = 32'h0001_0000;  // 64 KiB

  // Register offsets within each window
  localparam logic [ADDR_W-1:0] UART_TXDATA_OFS    = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] UART_STATUS_OFS    = 32'h0000_0004;
  localparam logic [ADDR_W-1:0] CLINT_MTIMECMP_OFS = 32'h0000_4000;  // High word at +4
  localparam logic [ADDR_W-1:0] CLINT_MTIME_OFS    = 32'h0000_bff8;  // High word at +4

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // ------------------------------
  // AXI-Lite channel payloads
  // ------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    axi_resp_e         resp;
  } axi_r_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    axi_resp_e resp;
  } axi_b_t;

  // One state per target and direction, held until the response handshake
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_RD_SRAM,
    ST_RD_UART,
    ST_RD_CLINT,
    ST_RD_ERR,
    ST_WR_SRAM,
    ST_WR_UART,
    ST_WR_CLINT,
    ST_WR_ERR
  } xbar_state_e;

endpackage

//--- verilog/periph_top.sv
module periph_top #(
  parameter int SRAM_WORDS = 1024
) (
  input  logic                 clk,
  input  logic                 rst,
  input  periph_pkg::axi_ar_t  cpu_ar_i,
  input  logic                 cpu_arvalid_i,
  output logic                 cpu_arready_o,
  output periph_pkg::axi_r_t   cpu_r_o,
  output logic                 cpu_rvalid_o,
  input  logic                 cpu_rready_i,
  input  periph_pkg::axi_aw_t  cpu_aw_i,
  input  logic                 cpu_awvalid_i,
  output logic                 cpu_awready_o,
  input  periph_pkg::axi_w_t   cpu_w_i,
  input  logic                 cpu_wvalid_i,
  output logic                 cpu_wready_o,
  output periph_pkg::axi_b_t   cpu_b_o,
  output logic                 cpu_bvalid_o,
  input  logic                 cpu_bready_i,
  output logic [7:0]           tx_data_o,
  output logic                 tx_valid_o,
  input  logic                 tx_ready_i,
  output logic                 timer_irq_o
);
  import periph_pkg::*;

  // Crossbar to slave channels
  axi_ar_t sram_ar, uart_ar, clint_ar;
  axi_r_t  sram_r, uart_r, clint_r;
  axi_aw_t sram_aw, uart_aw, clint_aw;
  axi_w_t  sram_w, uart_w, clint_w;
  axi_b_t  sram_b, uart_b, clint_b;
  logic    sram_arvalid, sram_arready, sram_rvalid, sram_rready;
  logic    sram_awvalid, sram_awready, sram_wvalid, sram_wready, sram_bvalid, sram_bready;
  logic    uart_arvalid, uart_arready, uart_rvalid, uart_rready;
  logic    uart_awvalid, uart_awready, uart_wvalid, uart_wready, uart_bvalid, uart_bready;
  logic    clint_arvalid, clint_arready, clint_rvalid, clint_rready;
  logic    clint_awvalid, clint_awready, clint_wvalid, clint_wready, clint_bvalid, clint_bready;

  axil_xbar xbar0 (
    .clk(clk), .rst(rst),
    .cpu_ar_i(cpu_ar_i), .cpu_arvalid_i(cpu_arvalid_i), .cpu_arready_o(cpu_arready_o),
    .cpu_r_o(cpu_r_o), .cpu_rvalid_o(cpu_rvalid_o), .cpu_rready_i(cpu_rready_i),
    .cpu_aw_i(cpu_aw_i), .cpu_awvalid_i(cpu_awvalid_i), .cpu_awready_o(cpu_awready_o),
    .cpu_w_i(cpu_w_i), .cpu_wvalid_i(cpu_wvalid_i), .cpu_wready_o(cpu_wready_o),
    .cpu_b_o(cpu_b_o), .cpu_bvalid_o(cpu_bvalid_o), .cpu_bready_i(cpu_bready_i),
    .sram_ar_o(sram_ar), .sram_arvalid_o(sram_arvalid), .sram_arready_i(sram_arready),
    .sram_r_i(sram_r), .sram_rvalid_i(sram_rvalid), .sram_rready_o(sram_rready),
    .sram_aw_o(sram_aw), .sram_awvalid_o(sram_awvalid), .sram_awready_i(sram_awready),
    .sram_w_o(sram_w), .sram_wvalid_o(sram_wvalid), .sram_wready_i(sram_wready),
    .sram_b_i(sram_b), .sram_bvalid_i(sram_bvalid), .sram_bready_o(sram_bready),
    .uart_ar_o(uart_ar), .uart_arvalid_o(uart_arvalid), .uart_arready_i(uart_arready),
    .uart_r_i(uart_r), .uart_rvalid_i(uart_rvalid), .uart_rready_o(uart_rready),
    .uart_aw_o(uart_aw), .uart_awvalid_o(uart_awvalid), .uart_awready_i(uart_awready),
    .uart_w_o(uart_w), .uart_wvalid_o(uart_wvalid), .uart_wready_i(uart_wready),
    .uart_b_i(uart_b), .uart_bvalid_i(uart_bvalid), .uart_bready_o(uart_bready),
    .clint_ar_o(clint_ar), .clint_arvalid_o(clint_arvalid), .clint_arready_i(clint_arready),
    .clint_r_i(clint_r), .clint_rvalid_i(clint_rvalid), .clint_rready_o(clint_rready),
    .clint_aw_o(clint_aw), .clint_awvalid_o(clint_awvalid), .clint_awready_i(clint_awready),
    .clint_w_o(clint_w), .clint_wvalid_o(clint_wvalid), .clint_wready_i(clint_wready),
    .clint_b_i(clint_b), .clint_bvalid_i(clint_bvalid), .clint_bready_o(clint_bready)
  );

  axil_sram #(
    .SRAM_WORDS(SRAM_WORDS)
  ) sram0 (
    .clk(clk), .rst(rst),
    .ar_i(sram_ar), .arvalid_i(sram_arvalid), .arready_o(sram_arready),
    .r_o(sram_r), .rvalid_o(sram_rvalid), .rready_i(sram_rready),
    .aw_i(sram_aw), .awvalid_i(sram_awvalid), .awready_o(sram_awready),
    .w_i(sram_w), .wvalid_i(sram_wvalid), .wready_o(sram_wready),
    .b_o(sram_b), .bvalid_o(sram_bvalid), .bready_i(sram_bready)
  );

  axil_uart_tx uart0 (
    .clk(clk), .rst(rst),
    .ar_i(uart_ar), .arvalid_i(uart_arvalid), .arready_o(uart_arready),
    .r_o(uart_r), .rvalid_o(uart_rvalid), .rready_i(uart_rready),
    .aw_i(uart_aw), .awvalid_i(uart_awvalid), .awready_o(uart_awready),
    .w_i(uart_w), .wvalid_i(uart_wvalid), .wready_o(uart_wready),
    .b_o(uart_b), .bvalid_o(uart_bvalid), .bready_i(uart_bready),
    .tx_data_o(tx_data_o), .tx_valid_o(tx_valid_o), .tx_ready_i(tx_ready_i)
  );

  axil_clint clint0 (
    .clk(clk), .rst(rst),
    .ar_i(clint_ar), .arvalid_i(clint_arvalid), .arready_o(clint_arready),
    .r_o(clint_r), .rvalid_o(clint_rvalid), .rready_i(clint_rready),
    .aw_i(clint_aw), .awvalid_i(clint_awvalid), .awready_o(clint_awready),
    .w_i(clint_w), .wvalid_i(clint_wvalid), .wready_o(clint_wready),
    .b_o(clint_b), .bvalid_o(clint_bvalid), .bready_i(clint_bready),
    .timer_irq_o(timer_irq_o)
  );

endmodule
